// File: Bender.yml
package:
  name: lsu_subsystem

sources:
  - files:
      - rtl/wired_pipe_pkg.sv
      - rtl/wired_lsu_pkg.sv
      - rtl/lsu_iq_entry.sv
      - rtl/lsu_issue_queue.sv
      - rtl/lsu_data_mem.sv
      - rtl/lsu_commit_fifo.sv
      - rtl/lsu_subsystem.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_lsu_subsystem.sv

// File: bench/tb_lsu_model.svh
`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

// one memory operation as dispatch would send it
typedef struct {
    mem_op_e     op;
    mem_type_e   mt;
    logic [11:0] imm;
    word_t       base;
    word_t       sdata;
    logic [1:0]  pend;      // bit 0 store data and bit 1 base wait on a tag
} mop_t;

typedef struct {
    rob_rid_t   wid;
    word_t      data;
    logic [1:0] excp;
} exp_t;

mop_t       prog[$];                            // operations still to dispatch
exp_t       exp_q[$];                           // results in dispatch order
logic [7:0] img [1024] = '{default: 8'h00};     // byte image of the 256 words

// bytes per access from the low type bits
function automatic int size_of(input mem_type_e mt);
    case (mt[1:0])
        2'd1: return 4;
        2'd2: return 2;
        default: return 1;
    endcase
endfunction

// runs one operation on the image and queues the result the core should see
function automatic void apply_op(input mop_t m, input rob_rid_t wid);
    word_t va;
    int    nb;
    logic  bad;
    exp_t  e;
    va = m.base + {{20{m.imm[11]}}, m.imm};
    nb = size_of(m.mt);
    bad = (nb == 4 && va[1:0] != 2'b00) || (nb == 2 && va[0]);
    e.wid = wid;
    e.excp = bad ? ex_ale : ex_none;
    e.data = '0;
    if (!bad) begin
        for (int b = 0; b < nb; b++) begin
            if (m.op == op_store) begin
                img[va[9:0] + b] = m.sdata[8*b +: 8];
            end else begin
                e.data[8*b +: 8] = img[va[9:0] + b];
            end
        end
        if (m.op == op_load && nb < 4 && !m.mt[2] && e.data[8*nb-1]) begin
            e.data = e.data | (32'hffff_ffff << (8 * nb));     // sign fill
        end
    end
    exp_q.push_back(e);
endfunction

`endif

// File: bench/tb_lsu_subsystem.sv
`timescale 1ns/1ps

module tb_lsu_subsystem;
    import wired_pipe_pkg::*;
    import wired_lsu_pkg::*;

    logic                   clk = 1'b0;
    logic                   rst_i;
    logic                   flush_i;
    logic [1:0]             p_valid_i;
    mem_op_e [1:0]          p_op_i;
    mem_type_e [1:0]        p_mem_type_i;
    logic [1:0][imm_w-1:0]  p_imm_i;
    rob_rid_t [1:0]         p_wid_i;
    logic [1:0][1:0]        p_src_rdy_i;
    rob_rid_t [1:0][1:0]    p_src_rid_i;
    word_t [1:0][1:0]       p_src_data_i;
    logic                   p_ready_o;
    logic [cdb_cnt-1:0]     cdb_valid_i;
    rob_rid_t [cdb_cnt-1:0] cdb_rid_i;
    word_t [cdb_cnt-1:0]    cdb_data_i;
    logic                   cdb_valid_o;
    logic                   cdb_ready_i;
    rob_rid_t               cdb_wid_o;
    word_t                  cdb_wdata_o;
    logic [1:0]             cdb_excp_o;

    // producer value still owed to a waiting operand
    typedef struct {
        rob_rid_t tag;
        word_t    data;
        int       due;
    } bcast_t;

    logic [31:0] lfsr = 32'h6373;
    bcast_t      bq[$];
    bcast_t      gq[$];            // held back until after the flush
    rob_rid_t    wid_ctr = '0;
    rob_rid_t    ptag = '0;
    logic        bp_on = 1'b0;
    logic        ghost = 1'b0;     // work that is going to be flushed
    int          bp_left = 0;
    int          cycle = 0;
    int          idle = 0;
    int          checks = 0;
    int          errors = 0;
    int          checks0 = 0;
    int          errors0 = 0;

    `include "tb_lsu_model.svh"

    lsu_subsystem dut (.*);

    always #4 clk = ~clk;

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic mem_type_e rand_type();
        case (rnd(3) % 5)
            0: return mt_w;
            1: return mt_h;
            2: return mt_b;
            3: return mt_hu;
            default: return mt_bu;
        endcase
    endfunction

    function automatic logic [9:0] aligned_addr(input mem_type_e mt, input logic [3:0] region);
        logic [9:0] a;
        a = {region, 6'(rnd(6))};
        if (mt[1:0] == 2'd1) begin
            a[1:0] = 2'b00;
        end else if (mt[1:0] == 2'd2) begin
            a[0] = 1'b0;
        end
        return a;
    endfunction

    function automatic mop_t gen_op(input mem_op_e op, input mem_type_e mt,
                                    input logic [9:0] addr, input logic [1:0] pend);
        mop_t m;
        m.op = op;
        m.mt = mt;
        m.imm = 12'(rnd(12));
        m.base = {22'(rnd(22)), addr} - {{20{m.imm[11]}}, m.imm};   // base plus imm hits addr
        m.sdata = rnd(32);
        m.pend = pend;
        return m;
    endfunction

    task automatic add_random(input int n, input logic [1:0] pmask, input logic [1:0] pforce);
        mem_type_e  mt;
        mem_op_e    op;
        logic [1:0] pend;
        for (int k = 0; k < n; k++) begin
            mt = rand_type();
            op = mem_op_e'(rnd(1));
            pend = (2'(rnd(2)) & pmask) | pforce;
            prog.push_back(gen_op(op, mt, aligned_addr(mt, 4'h0), pend));
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h (cycle %0d)", name, got, want, cycle);
        end
    endtask

    task automatic take_result();
        exp_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Unexpected result with tag %h at cycle %0d", cdb_wid_o, cycle);
        end else begin
            e = exp_q.pop_front();
            check("cdb_wid_o", 32'(cdb_wid_o), 32'(e.wid));
            check("cdb_wdata_o", cdb_wdata_o, e.data);
            check("cdb_excp_o", 32'(cdb_excp_o), 32'(e.excp));
        end
        idle = 0;
    endtask

    // new inputs on the falling edge and the result that pops at the next rising edge
    task automatic step();
        @(negedge clk);
        cycle++;
        idle++;
        p_valid_i = 2'b00;
        cdb_valid_i = '0;
        if (bp_left == 0) begin
            bp_left = 1 + int'(rnd(3));
            cdb_ready_i = !bp_on || rnd(1);
        end
        bp_left--;
        if (cdb_valid_o && cdb_ready_i) take_result();
    endtask

    task automatic drive_cdb();
        int   bus;
        logic sw;
        sw = rnd(1);
        for (int k = 0; k < cdb_cnt; k++) begin
            if (bq.size() > 0 && bq[0].due <= cycle) begin
                bus = k ^ sw;
                cdb_valid_i[bus] = 1'b1;
                cdb_rid_i[bus] = bq[0].tag;
                cdb_data_i[bus] = bq[0].data;
                void'(bq.pop_front());
            end
        end
    endtask

    task automatic set_operand(input int l, input int j, input word_t val, input logic pend);
        bcast_t b;
        p_src_rdy_i[l][j] = !pend;
        p_src_rid_i[l][j] = pend ? ptag : rob_rid_t'(rnd(5));
        p_src_data_i[l][j] = pend ? rnd(32) : val;     // junk while waiting
        if (pend) begin
            b.tag = ptag;
            b.data = val;
            b.due = cycle + int'(rnd(2));               // may be this very cycle
            if (ghost) begin
                gq.push_back(b);
            end else begin
                bq.push_back(b);
            end
        end
        if (pend) ptag++;
    endtask

    task automatic dispatch_lane(input int l, input mop_t m);
        p_valid_i[l] = 1'b1;
        p_op_i[l] = m.op;
        p_mem_type_i[l] = m.mt;
        p_imm_i[l] = m.imm;
        p_wid_i[l] = wid_ctr;
        set_operand(l, 0, m.sdata, m.pend[0]);
        set_operand(l, 1, m.base, m.pend[1]);
        if (!ghost) apply_op(m, wid_ctr);
        wid_ctr++;
    endtask

    task automatic pulse_flush();
        step();
        flush_i = 1'b1;
        step();
        flush_i = 1'b0;
    endtask

    task automatic run_program(input int limit);
        int idx;
        int lanes;
        idx = 0;
        idle = 0;
        while ((idx < prog.size() || exp_q.size() > 0 || bq.size() > 0) && idle <= limit) begin
            step();
            if (p_ready_o) begin
                lanes = int'(rnd(2)) % 3;
                for (int l = 0; l < lanes && idx < prog.size(); l++) begin
                    dispatch_lane(l, prog[idx]);
                    idx++;
                    idle = 0;
                end
            end
            drive_cdb();
        end
        if (idle > limit) begin
            errors++;
            $display("Timeout: no result within %0d cycles, %0d still expected",
                     limit, exp_q.size());
            exp_q.delete();
            bq.delete();
            pulse_flush();
        end
        prog.delete();
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checks - checks0, errors - errors0);
        checks0 = checks;
        errors0 = errors;
    endtask

    initial begin
        mop_t       m;
        logic [9:0] a, oh, ob;
        mem_type_e  mt;
        rst_i = 1'b1;
        flush_i = 1'b0;
        p_valid_i = 2'b00;
        for (int l = 0; l < 2; l++) begin
            p_op_i[l] = op_load;
            p_mem_type_i[l] = mt_w;
        end
        p_imm_i = '0;
        p_wid_i = '0;
        p_src_rdy_i = '0;
        p_src_rid_i = '0;
        p_src_data_i = '0;
        cdb_valid_i = '0;
        cdb_rid_i = '0;
        cdb_data_i = '0;
        cdb_ready_i = 1'b1;
        repeat (2) @(negedge clk);      // two rising edges in reset
        rst_i = 1'b0;
        check("cdb_valid_o", 32'(cdb_valid_o), 32'd0);
        check("p_ready_o", 32'(p_ready_o), 32'd1);

        for (int k = 0; k < 24; k++) begin
            mt = rand_type();
            m = gen_op(k < 12 ? op_store : op_load, mt, aligned_addr(mt, 4'h0), 2'b00);
            prog.push_back(m);
        end
        run_program(100);
        end_test(1, "aligned stores then loads");

        for (int k = 0; k < 5; k++) begin
            a = aligned_addr(mt_w, 4'h1);
            oh = 10'(2 * rnd(1));
            ob = 10'(rnd(2));
            m = gen_op(op_store, mt_w, a, 2'b00);
            m.sdata = m.sdata | 32'h8080_8080;          // every byte negative
            prog.push_back(m);
            prog.push_back(gen_op(op_load, mt_h, a + oh, 2'b00));
            prog.push_back(gen_op(op_load, mt_hu, a + oh, 2'b00));
            prog.push_back(gen_op(op_load, mt_b, a + ob, 2'b00));
            prog.push_back(gen_op(op_load, mt_bu, a + ob, 2'b00));
        end
        run_program(100);
        end_test(2, "signedness");

        for (int k = 0; k < 4; k++) begin
            a = aligned_addr(mt_w, 4'h2);
            prog.push_back(gen_op(op_store, mt_w, a, 2'b00));
            prog.push_back(gen_op(op_store, mt_h, a + 10'(1 + 2 * rnd(1)), 2'b00));
            prog.push_back(gen_op(op_store, mt_w, a + 10'(1 + rnd(1)), 2'b00));
            prog.push_back(gen_op(op_load, mt_hu, a + 10'd1, 2'b00));
            prog.push_back(gen_op(op_load, mt_w, a + 10'd3, 2'b00));
            prog.push_back(gen_op(op_load, mt_w, a, 2'b00));   // word must be unchanged
        end
        run_program(100);
        end_test(3, "misaligned accesses");

        add_random(24, 2'b11, 2'b00);
        run_program(100);
        end_test(4, "operand wake-up");

        bp_on = 1'b1;
        add_random(60, 2'b11, 2'b00);
        run_program(150);
        bp_on = 1'b0;
        end_test(5, "back-pressure");

        // these see their operands only after the flush and must stay gone
        ghost = 1'b1;
        add_random(6, 2'b00, 2'b11);
        run_program(100);
        ghost = 1'b0;
        pulse_flush();
        bq = gq;
        gq.delete();
        for (int k = 0; k < 40; k++) begin
            step();
            drive_cdb();
        end
        add_random(16, 2'b11, 2'b00);
        run_program(100);
        end_test(6, "flush");

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+bench
rtl/wired_pipe_pkg.sv
rtl/wired_lsu_pkg.sv
rtl/lsu_iq_entry.sv
rtl/lsu_issue_queue.sv
rtl/lsu_data_mem.sv
rtl/lsu_commit_fifo.sv
rtl/lsu_subsystem.sv
bench/tb_lsu_subsystem.sv

// File: rtl/lsu_commit_fifo.sv
`timescale 1ns/1ps

module lsu_commit_fifo #(
    parameter int EXCP_W = 2
) (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     flush_i,

    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  wired_pipe_pkg::rob_rid_t in_wid_i,
    input  wired_pipe_pkg::word_t    in_data_i,
    input  logic [EXCP_W-1:0]        in_excp_i,

    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output wired_pipe_pkg::rob_rid_t out_wid_o,
    output wired_pipe_pkg::word_t    out_data_o,
    output logic [EXCP_W-1:0]        out_excp_o
);
    import wired_pipe_pkg::*;

    rob_rid_t          wid_q [2];
    word_t             data_q [2];
    logic [EXCP_W-1:0] excp_q [2];
    logic              wr_ptr_q, rd_ptr_q;
    logic [1:0]        cnt_q;
    logic              push, pop;

    assign in_ready_o = cnt_q != 2'd2;
    assign out_valid_o = cnt_q != 2'd0;
    assign push = in_valid_i && in_ready_o;
    assign pop = out_valid_o && out_ready_i;

    assign out_wid_o = wid_q[rd_ptr_q];
    assign out_data_o = data_q[rd_ptr_q];
    assign out_excp_o = excp_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            cnt_q <= 2'd0;
        end else begin
            wr_ptr_q <= wr_ptr_q ^ push;
            rd_ptr_q <= rd_ptr_q ^ pop;
            cnt_q <= cnt_q + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            wid_q[wr_ptr_q] <= in_wid_i;
            data_q[wr_ptr_q] <= in_data_i;
            excp_q[wr_ptr_q] <= in_excp_i;
        end
    end

    // a response refused while full must be held by the memory until taken
    a_hold_full: assert property (@(posedge clk) disable iff (rst_i || flush_i)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_wid_i) && $stable(in_data_i))
        else $error("lsu_commit_fifo: response lost while full");

endmodule

// File: rtl/lsu_data_mem.sv
`timescale 1ns/1ps

module lsu_data_mem (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     flush_i,

    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  wired_pipe_pkg::rob_rid_t req_wid_i,
    input  wired_lsu_pkg::mem_op_e   req_op_i,
    input  wired_lsu_pkg::msize_e    req_msize_i,
    input  logic                     req_msigned_i,
    input  wired_pipe_pkg::word_t    req_vaddr_i,
    input  logic [3:0]               req_strb_i,
    input  wired_pipe_pkg::word_t    req_wdata_i,

    output logic                     resp_valid_o,
    input  logic                     resp_ready_i,
    output wired_pipe_pkg::rob_rid_t resp_wid_o,
    output wired_pipe_pkg::word_t    resp_rdata_o,
    output wired_lsu_pkg::excp_e     resp_excp_o
);
    import wired_pipe_pkg::*;
    import wired_lsu_pkg::*;

    word_t mem_q [dmem_words] = '{default: '0};

    logic [dmem_aw-1:0] idx;
    logic               acc, misalign;
    word_t              rword, rdata;
    logic [7:0]         rbyte;
    logic [15:0]        rhalf;

    assign req_ready_o = !resp_valid_o || resp_ready_i;    // response slot free or draining
    assign acc = req_valid_i && req_ready_o && !flush_i;
    assign idx = req_vaddr_i[dmem_aw+1:2];

    assign misalign = (req_msize_i == sz_half && req_vaddr_i[0])
                   || (req_msize_i == sz_word && req_vaddr_i[1:0] != 2'b00);

    assign rword = mem_q[idx];
    assign rbyte = 8'(rword >> {req_vaddr_i[1:0], 3'b000});
    assign rhalf = 16'(rword >> {req_vaddr_i[1], 4'b0000});

    // load extraction and extension
    always_comb begin
        case (req_msize_i)
            sz_byte: rdata = {{(word_w-8){req_msigned_i && rbyte[7]}}, rbyte};
            sz_half: rdata = {{(word_w-16){req_msigned_i && rhalf[15]}}, rhalf};
            default: rdata = rword;
        endcase
        if (req_op_i == op_store || misalign) begin
            rdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (acc && req_op_i == op_store && !misalign) begin
            for (int b = 0; b < 4; b++) begin
                if (req_strb_i[b]) begin
                    mem_q[idx][8*b +: 8] <= req_wdata_i[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            resp_valid_o <= 1'b0;
        end else if (req_ready_o) begin
            resp_valid_o <= req_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            resp_wid_o <= req_wid_i;
            resp_rdata_o <= rdata;
            resp_excp_o <= misalign ? ex_ale : ex_none;
        end
    end

endmodule

// File: rtl/lsu_iq_entry.sv
`timescale 1ns/1ps

module lsu_iq_entry #(
    parameter int PAYLOAD_W = 21
) (
    input  logic                                            clk,
    input  logic                                            rst_i,
    input  logic                                            flush_i,
    input  logic                                            alloc_i,
    input  logic                                            sel_i,
    input  logic [1:0]                                      src_rdy_i,
    input  wired_pipe_pkg::rob_rid_t [1:0]                  src_rid_i,
    input  wired_pipe_pkg::word_t [1:0]                     src_data_i,
    input  logic [PAYLOAD_W-1:0]                            payload_i,
    input  logic [wired_pipe_pkg::cdb_cnt-1:0]              cdb_valid_i,
    input  wired_pipe_pkg::rob_rid_t [wired_pipe_pkg::cdb_cnt-1:0] cdb_rid_i,
    input  wired_pipe_pkg::word_t [wired_pipe_pkg::cdb_cnt-1:0]    cdb_data_i,
    output logic                                            empty_o,
    output logic                                            ready_o,
    output wired_pipe_pkg::word_t [1:0]                     data_o,
    output logic [PAYLOAD_W-1:0]                            payload_o
);
    import wired_pipe_pkg::*;

    logic                 occ_q;
    logic [1:0]           rdy_q;
    rob_rid_t [1:0]       rid_q;
    word_t [1:0]          data_q;
    logic [PAYLOAD_W-1:0] payload_q;

    rob_rid_t [1:0]       snoop_rid;
    logic [1:0]           hit;
    word_t [1:0]          hit_data;

    // compare each operand tag against every result bus
    always_comb begin
        for (int j = 0; j < 2; j++) begin
            snoop_rid[j] = alloc_i ? src_rid_i[j] : rid_q[j];  // new tag while allocating
            hit[j] = 1'b0;
            hit_data[j] = '0;
            for (int c = 0; c < cdb_cnt; c++) begin
                if (cdb_valid_i[c] && cdb_rid_i[c] == snoop_rid[j]) begin
                    hit[j] = 1'b1;
                    hit_data[j] = cdb_data_i[c];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            occ_q <= 1'b0;
            rdy_q <= 2'b00;
        end else begin
            if (alloc_i) begin
                occ_q <= 1'b1;
            end else if (sel_i) begin
                occ_q <= 1'b0;          // issued
            end
            rdy_q <= alloc_i ? (src_rdy_i | hit) : (rdy_q | hit);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            payload_q <= payload_i;
            rid_q <= src_rid_i;
        end
        for (int j = 0; j < 2; j++) begin
            if (alloc_i) begin
                data_q[j] <= src_rdy_i[j] ? src_data_i[j] : hit_data[j];
            end else if (!rdy_q[j] && hit[j]) begin
                data_q[j] <= hit_data[j];   // wake-up
            end
        end
    end

    assign empty_o = !occ_q;
    assign ready_o = occ_q && (&rdy_q);
    assign data_o = data_q;
    assign payload_o = payload_q;

    // queue pointers must only ever land on a free slot
    a_alloc_free: assert property (@(posedge clk) disable iff (rst_i)
        alloc_i |-> !occ_q)
        else $error("lsu_iq_entry: allocation into an occupied entry");

endmodule

// File: rtl/lsu_issue_queue.sv
`timescale 1ns/1ps

module lsu_issue_queue (
    input  logic                                         clk,
    input  logic                                         rst_i,
    input  logic                                         flush_i,

    input  logic [1:0]                                   p_valid_i,
    input  wired_lsu_pkg::mem_op_e [1:0]                 p_op_i,
    input  wired_lsu_pkg::mem_type_e [1:0]               p_mem_type_i,
    input  logic [1:0][wired_lsu_pkg::imm_w-1:0]         p_imm_i,
    input  wired_pipe_pkg::rob_rid_t [1:0]               p_wid_i,
    input  logic [1:0][1:0]                              p_src_rdy_i,   // [lane][operand]
    input  wired_pipe_pkg::rob_rid_t [1:0][1:0]          p_src_rid_i,
    input  wired_pipe_pkg::word_t [1:0][1:0]             p_src_data_i,
    output logic                                         p_ready_o,

    input  logic [wired_pipe_pkg::cdb_cnt-1:0]           cdb_valid_i,
    input  wired_pipe_pkg::rob_rid_t [wired_pipe_pkg::cdb_cnt-1:0] cdb_rid_i,
    input  wired_pipe_pkg::word_t [wired_pipe_pkg::cdb_cnt-1:0]    cdb_data_i,

    output logic                                         lsu_req_valid_o,
    input  logic                                         lsu_req_ready_i,
    output wired_pipe_pkg::rob_rid_t                     lsu_req_wid_o,
    output wired_lsu_pkg::mem_op_e                       lsu_req_op_o,
    output wired_lsu_pkg::msize_e                        lsu_req_msize_o,
    output logic                                         lsu_req_msigned_o,
    output wired_pipe_pkg::word_t                        lsu_req_vaddr_o,
    output logic [3:0]                                   lsu_req_strb_o,
    output wired_pipe_pkg::word_t                        lsu_req_wdata_o
);
    import wired_pipe_pkg::*;
    import wired_lsu_pkg::*;

    // entry payload is {op, mem type, imm, wid}
    localparam int pl_w = $bits(mem_op_e) + $bits(mem_type_e) + imm_w + rid_w;

    logic [lsu_iq_ptr_w-1:0]              head_q, head_p1_q, tail_q;
    logic [lsu_iq_ptr_w:0]                cnt_q, cnt_d, n_take;
    logic [1:0]                           take;
    logic                                 top_valid, stage_ready, top_fire;

    logic [lsu_iq_depth-1:0]              empty, ready;
    word_t [lsu_iq_depth-1:0][1:0]        ent_data;
    logic [lsu_iq_depth-1:0][pl_w-1:0]    ent_pl;
    logic [1:0][pl_w-1:0]                 lane_pl;

    word_t [1:0]                          s_data;
    logic [pl_w-1:0]                      s_pl;
    mem_op_e                              s_op;
    mem_type_e                            s_mt;
    logic [imm_w-1:0]                     s_imm;
    rob_rid_t                             s_wid;
    word_t                                s_vaddr, s_wdata;
    msize_e                               s_msize;
    logic [3:0]                           s_strb;

    // lanes only count while the queue advertises room
    assign take = (p_ready_o && !flush_i) ? p_valid_i : 2'b00;
    assign n_take = {{lsu_iq_ptr_w{1'b0}}, take[0]} + {{lsu_iq_ptr_w{1'b0}}, take[1]};

    assign top_valid = ready[tail_q];                       // strictly in order
    assign stage_ready = !lsu_req_valid_o || lsu_req_ready_i;
    assign top_fire = top_valid && stage_ready;
    assign cnt_d = cnt_q + n_take - {{lsu_iq_ptr_w{1'b0}}, top_fire};

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            head_q <= '0;
            head_p1_q <= lsu_iq_ptr_w'(1);
            tail_q <= '0;
            cnt_q <= '0;
            p_ready_o <= 1'b1;
        end else begin
            head_q <= head_q + n_take[lsu_iq_ptr_w-1:0];
            head_p1_q <= head_p1_q + n_take[lsu_iq_ptr_w-1:0];
            tail_q <= tail_q + lsu_iq_ptr_w'(top_fire);
            cnt_q <= cnt_d;
            p_ready_o <= cnt_d <= lsu_iq_depth - 2;    // room for two more
        end
    end

    for (genvar l = 0; l < 2; l++) begin : g_lane
        assign lane_pl[l] = {p_op_i[l], p_mem_type_i[l], p_imm_i[l], p_wid_i[l]};
    end

    for (genvar i = 0; i < lsu_iq_depth; i++) begin : g_ent
        logic is_h0, is_h1, upd0, upd1;

        assign is_h0 = head_q == lsu_iq_ptr_w'(i);
        assign is_h1 = head_p1_q == lsu_iq_ptr_w'(i);
        assign upd0 = is_h0 && take[0];
        // lane 1 falls back to head when lane 0 is idle
        assign upd1 = take[1] && ((is_h0 && !take[0]) || (is_h1 && take[0]));

        lsu_iq_entry #(
            .PAYLOAD_W(pl_w)
        ) u_ent (
            .clk         (clk),
            .rst_i       (rst_i),
            .flush_i     (flush_i),
            .alloc_i     (upd0 || upd1),
            .sel_i       (top_fire && tail_q == lsu_iq_ptr_w'(i)),
            .src_rdy_i   (p_src_rdy_i[upd1]),
            .src_rid_i   (p_src_rid_i[upd1]),
            .src_data_i  (p_src_data_i[upd1]),
            .payload_i   (lane_pl[upd1]),
            .cdb_valid_i (cdb_valid_i),
            .cdb_rid_i   (cdb_rid_i),
            .cdb_data_i  (cdb_data_i),
            .empty_o     (empty[i]),
            .ready_o     (ready[i]),
            .data_o      (ent_data[i]),
            .payload_o   (ent_pl[i])
        );
    end

    // request formatting from the oldest entry
    assign s_data = ent_data[tail_q];
    assign s_pl = ent_pl[tail_q];
    assign s_op = mem_op_e'(s_pl[pl_w-1]);
    assign s_mt = mem_type_e'(s_pl[pl_w-2 -: 3]);
    assign s_imm = s_pl[rid_w +: imm_w];
    assign s_wid = s_pl[rid_w-1:0];
    assign s_vaddr = {{(word_w-imm_w){s_imm[imm_w-1]}}, s_imm} + s_data[1];

    always_comb begin
        case (s_mt[1:0])
            2'd1: begin
                s_msize = sz_word;
                s_strb = 4'b1111;
                s_wdata = s_data[0];
            end
            2'd2: begin
                s_msize = sz_half;
                s_strb = 4'b0011 << {s_vaddr[1], 1'b0};
                s_wdata = s_data[0] << {s_vaddr[1], 4'b0000};
            end
            default: begin
                s_msize = sz_byte;
                s_strb = 4'b0001 << s_vaddr[1:0];
                s_wdata = s_data[0] << {s_vaddr[1:0], 3'b000};
            end
        endcase
        if (s_op == op_load) begin
            s_strb = 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            lsu_req_valid_o <= 1'b0;
        end else if (stage_ready) begin
            lsu_req_valid_o <= top_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (top_fire) begin
            lsu_req_wid_o <= s_wid;
            lsu_req_op_o <= s_op;
            lsu_req_msize_o <= s_msize;
            lsu_req_msigned_o <= !s_mt[2];
            lsu_req_vaddr_o <= s_vaddr;
            lsu_req_strb_o <= s_strb;
            lsu_req_wdata_o <= s_wdata;
        end
    end

    a_cnt_max: assert property (@(posedge clk) disable iff (rst_i)
        cnt_q <= lsu_iq_depth)
        else $error("lsu_issue_queue: count above depth");

    a_lane_order: assert property (@(posedge clk) disable iff (rst_i)
        p_valid_i[1] |-> p_valid_i[0])
        else $error("lsu_issue_queue: lane 1 valid without lane 0");

    // pointer bookkeeping agrees with the entries themselves
    a_occupancy: assert property (@(posedge clk) disable iff (rst_i)
        $countones(~empty) == cnt_q)
        else $error("lsu_issue_queue: count does not match occupied entries");

endmodule

// File: rtl/lsu_subsystem.sv
`timescale 1ns/1ps

module lsu_subsystem (
    input  logic                                         clk,
    input  logic                                         rst_i,
    input  logic                                         flush_i,

    input  logic [1:0]                                   p_valid_i,
    input  wired_lsu_pkg::mem_op_e [1:0]                 p_op_i,
    input  wired_lsu_pkg::mem_type_e [1:0]               p_mem_type_i,
    input  logic [1:0][wired_lsu_pkg::imm_w-1:0]         p_imm_i,
    input  wired_pipe_pkg::rob_rid_t [1:0]               p_wid_i,
    input  logic [1:0][1:0]                              p_src_rdy_i,
    input  wired_pipe_pkg::rob_rid_t [1:0][1:0]          p_src_rid_i,
    input  wired_pipe_pkg::word_t [1:0][1:0]             p_src_data_i,
    output logic                                         p_ready_o,

    input  logic [wired_pipe_pkg::cdb_cnt-1:0]           cdb_valid_i,
    input  wired_pipe_pkg::rob_rid_t [wired_pipe_pkg::cdb_cnt-1:0] cdb_rid_i,
    input  wired_pipe_pkg::word_t [wired_pipe_pkg::cdb_cnt-1:0]    cdb_data_i,

    output logic                                         cdb_valid_o,
    input  logic                                         cdb_ready_i,
    output wired_pipe_pkg::rob_rid_t                     cdb_wid_o,
    output wired_pipe_pkg::word_t                        cdb_wdata_o,
    output logic [$bits(wired_lsu_pkg::excp_e)-1:0]      cdb_excp_o
);
    import wired_pipe_pkg::*;
    import wired_lsu_pkg::*;

    logic       req_valid, req_ready, req_msigned;
    rob_rid_t   req_wid;
    mem_op_e    req_op;
    msize_e     req_msize;
    word_t      req_vaddr, req_wdata;
    logic [3:0] req_strb;

    logic       resp_valid, resp_ready;
    rob_rid_t   resp_wid;
    word_t      resp_rdata;
    excp_e      resp_excp;

    lsu_issue_queue u_iq (
        .clk               (clk),
        .rst_i             (rst_i),
        .flush_i           (flush_i),
        .p_valid_i         (p_valid_i),
        .p_op_i            (p_op_i),
        .p_mem_type_i      (p_mem_type_i),
        .p_imm_i           (p_imm_i),
        .p_wid_i           (p_wid_i),
        .p_src_rdy_i       (p_src_rdy_i),
        .p_src_rid_i       (p_src_rid_i),
        .p_src_data_i      (p_src_data_i),
        .p_ready_o         (p_ready_o),
        .cdb_valid_i       (cdb_valid_i),
        .cdb_rid_i         (cdb_rid_i),
        .cdb_data_i        (cdb_data_i),
        .lsu_req_valid_o   (req_valid),
        .lsu_req_ready_i   (req_ready),
        .lsu_req_wid_o     (req_wid),
        .lsu_req_op_o      (req_op),
        .lsu_req_msize_o   (req_msize),
        .lsu_req_msigned_o (req_msigned),
        .lsu_req_vaddr_o   (req_vaddr),
        .lsu_req_strb_o    (req_strb),
        .lsu_req_wdata_o   (req_wdata)
    );

    lsu_data_mem u_mem (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .req_valid_i   (req_valid),
        .req_ready_o   (req_ready),
        .req_wid_i     (req_wid),
        .req_op_i      (req_op),
        .req_msize_i   (req_msize),
        .req_msigned_i (req_msigned),
        .req_vaddr_i   (req_vaddr),
        .req_strb_i    (req_strb),
        .req_wdata_i   (req_wdata),
        .resp_valid_o  (resp_valid),
        .resp_ready_i  (resp_ready),
        .resp_wid_o    (resp_wid),
        .resp_rdata_o  (resp_rdata),
        .resp_excp_o   (resp_excp)
    );

    lsu_commit_fifo #(
        .EXCP_W($bits(excp_e))
    ) u_fifo (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .in_valid_i  (resp_valid),
        .in_ready_o  (resp_ready),
        .in_wid_i    (resp_wid),
        .in_data_i   (resp_rdata),
        .in_excp_i   (resp_excp),
        .out_valid_o (cdb_valid_o),
        .out_ready_i (cdb_ready_i),
        .out_wid_o   (cdb_wid_o),
        .out_data_o  (cdb_wdata_o),
        .out_excp_o  (cdb_excp_o)
    );

endmodule

// File: rtl/wired_lsu_pkg.sv
package wired_lsu_pkg;

    // bit 2 set for unsigned and low bits 1 word 2 half 3 byte
    typedef enum logic [2:0] {
        mt_w  = 3'b001,
        mt_h  = 3'b010,
        mt_b  = 3'b011,
        mt_hu = 3'b110,
        mt_bu = 3'b111
    } mem_type_e;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    typedef enum logic [1:0] {
        sz_byte = 2'd0,
        sz_half = 2'd1,
        sz_word = 2'd2
    } msize_e;

    typedef enum logic [1:0] {
        ex_none = 2'd0,
        ex_ale  = 2'd1      // misaligned access
    } excp_e;

    localparam int imm_w = 12;

    // data memory, word addressed
    localparam int dmem_words = 256;
    localparam int dmem_aw = $clog2(dmem_words);

endpackage

// File: rtl/wired_pipe_pkg.sv
package wired_pipe_pkg;

    localparam int word_w = 32;
    localparam int rid_w = 5;

    // result buses snooped by the issue queue
    localparam int cdb_cnt = 2;

    localparam int lsu_iq_depth = 8;                    // power of two, pointers wrap
    localparam int lsu_iq_ptr_w = $clog2(lsu_iq_depth);

    typedef logic [word_w-1:0] word_t;
    typedef logic [rid_w-1:0] rob_rid_t;                // reorder buffer tag

endpackage
